// File: Bender.yml
package:
  name: dmem

sources:
  - verilog/dmem_pkg.sv
  - verilog/dmem_lsu.sv
  - verilog/wb_master.sv
  - verilog/wb_ram.sv
  - verilog/dmem_top.sv
  - target: test
    files:
      - bench/tb_dmem.sv

// File: bench/dmem_trace.txt
# test op addr wdata exp_rdata exp_err (test in decimal, the rest in hex)
# rows with the same test number are issued back to back with no idle cycle
1 SW 00000010 deadbeef 00000000 0
1 LW 00000010 00000000 deadbeef 0
1 LW 000003fc 00000000 00000000 0
2 SB 00000040 000000aa 00000000 0
2 SB 00000041 12345655 00000000 0
2 SH 00000042 0000cafe 00000000 0
2 LW 00000040 00000000 cafe55aa 0
3 SW 00000060 80ff7f81 00000000 0
3 LB 00000060 00000000 ffffff81 0
3 LBU 00000060 00000000 00000081 0
3 LB 00000061 00000000 0000007f 0
3 LBU 00000063 00000000 00000080 0
3 LH 00000062 00000000 ffff80ff 0
3 LHU 00000062 00000000 000080ff 0
3 LH 00000060 00000000 00007f81 0
4 SW 00000070 12345678 00000000 0
4 SH 00000071 0000ffff 00000000 1
4 SW 00000072 aaaaaaaa 00000000 1
4 LW 00000073 00000000 00000000 1
4 LW 00000070 00000000 12345678 0
5 SW 00000000 01020304 00000000 0
5 SW 00000400 ffffffff 00000000 1
5 SW 10000000 ffffffff 00000000 1
5 LW 00000400 00000000 00000000 1
5 LW 00000000 00000000 01020304 0
6 SW 00000100 11111111 00000000 0
6 SB 00000105 00000022 00000000 0
6 LW 00000100 00000000 11111111 0
6 LW 00000104 00000000 00002200 0
6 LH 00000101 00000000 00000000 1
6 LHU 00000104 00000000 00002200 0

// File: bench/tb_dmem.sv
module tb_dmem;
	timeunit 1ns;
	timeprecision 100ps;
	import dmem_pkg::*;

	localparam int CLK_PERIOD  = 8;
	localparam int RAM_WORDS   = 256;
	localparam int ACK_LATENCY = 2;

	// one row of the trace file.
	typedef struct packed {
		logic [15:0]         test;
		mem_op_e             op;
		logic [ADR_W-1:0]    addr;
		logic [DATA_W-1:0]   wdata;
		logic [DATA_W-1:0]   rdata;
		logic                err;
	} trace_t;

	logic       clk;
	logic       rst_n;
	logic       req_valid;
	mem_req_t   req;
	logic       done;
	mem_rsp_t   rsp;
	trace_t     trace [$];
	logic       loaded = 1'b0;

	dmem_top #(
		.ADDRESS_WIDTH (ADR_W),
		.RAM_WORDS     (RAM_WORDS),
		.ACK_LATENCY   (ACK_LATENCY)
	) dut (
		.wb_clk_i    (clk),
		.rst_n_i     (rst_n),
		.req_valid_i (req_valid),
		.req_i       (req),
		.done_o      (done),
		.rsp_o       (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic bit decode_op(input string name, output mem_op_e op);
		op = OP_LW;
		case (name)
			"LB":    op = OP_LB;
			"LBU":   op = OP_LBU;
			"LH":    op = OP_LH;
			"LHU":   op = OP_LHU;
			"LW":    op = OP_LW;
			"SB":    op = OP_SB;
			"SH":    op = OP_SH;
			"SW":    op = OP_SW;
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	task automatic load_trace();
		int                  fd;
		int                  test;
		int                  err;
		string               line;
		string               name;
		logic [ADR_W-1:0]    addr;
		logic [DATA_W-1:0]   wdata;
		logic [DATA_W-1:0]   rdata;
		mem_op_e             op;
		fd = $fopen("bench/dmem_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file bench/dmem_trace.txt.");
			$display("TEST FAILED");
			$fatal(1, "trace file missing");
		end
		while ($fgets(line, fd)) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue; // blank or comment line.
			end
			if ($sscanf(line, "%d %s %h %h %h %d", test, name, addr, wdata, rdata, err) != 6
					|| !decode_op(name, op)) begin
				$display("The trace line could not be read: %s", line);
				$display("TEST FAILED");
				$fatal(1, "bad trace line");
			end
			trace.push_back('{test: 16'(test), op: op, addr: addr, wdata: wdata,
				rdata: rdata, err: err[0]});
		end
		$fclose(fd);
	endtask

	// watchdog, scaled to the number of requests.
	initial begin
		wait (loaded === 1'b1);
		repeat (trace.size() * 20 + 10) @(posedge clk);
		$display("The DUT hung: the trace did not finish within %0d cycles.",
			trace.size() * 20 + 10);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		trace_t t;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		load_trace();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (done === 1'b0) else begin
			$display("done_o is high right after reset.");
			$display("TEST FAILED");
			$fatal(1, "done after reset");
		end
		foreach (trace[i]) begin
			t = trace[i];
			req_valid = 1'b1;
			req = '{op: t.op, addr: t.addr, wdata: t.wdata};
			do begin
				@(negedge clk);
			end while (done !== 1'b1);
			assert (rsp.err === t.err) else begin
				$display("Fail test %0d %s @%h: err expected %b, actual %b",
					t.test, t.op.name(), t.addr, t.err, rsp.err);
				$display("TEST FAILED");
				$fatal(1, "error bit mismatch");
			end
			assert (rsp.rdata === t.rdata) else begin
				$display("Fail test %0d %s @%h: rdata expected %h, actual %h",
					t.test, t.op.name(), t.addr, t.rdata, rsp.rdata);
				$display("TEST FAILED");
				$fatal(1, "read data mismatch");
			end
			// the request stays up through the done cycle.
			@(negedge clk);
			if (i + 1 == trace.size() || trace[i + 1].test != t.test) begin
				req_valid = 1'b0; // a new test number starts after one idle cycle.
				@(negedge clk);
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: verilog.f
verilog/dmem_pkg.sv
verilog/dmem_lsu.sv
verilog/wb_master.sv
verilog/wb_ram.sv
verilog/dmem_top.sv
bench/tb_dmem.sv

// File: verilog/dmem_lsu.sv
module dmem_lsu #(
	parameter int ADDRESS_WIDTH = dmem_pkg::ADR_W
) (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic                          req_valid_i,
	input  dmem_pkg::mem_req_t            req_i,
	output logic                          done_o,
	output dmem_pkg::mem_rsp_t            rsp_o,
	output logic                          bus_en_o,
	output dmem_pkg::bus_req_t            bus_req_o,
	input  logic                          bus_done_i,
	input  logic                          bus_err_i,
	input  logic [dmem_pkg::DATA_W-1:0]   bus_rdata_i
);
	import dmem_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUS,
		S_DONE
	} state_e;

	state_e              state_q;
	logic                is_store;
	logic                misaligned;
	logic [SEL_W-1:0]    sel;
	logic [DATA_W-1:0]   lane_data;
	logic [DATA_W-1:0]   shifted;
	logic [DATA_W-1:0]   load_data;
	logic                bus_fin;
	mem_rsp_t            rsp_live;
	mem_rsp_t            rsp_q;

	assign is_store = req_i.op inside {OP_SB, OP_SH, OP_SW};

	// lane placement and alignment check.
	always_comb begin
		misaligned = 1'b0;
		sel = '0;
		lane_data = req_i.wdata;
		case (req_i.op)
			OP_LB, OP_LBU, OP_SB: begin
				sel = 4'b0001 << req_i.addr[1:0];
				lane_data = {4{req_i.wdata[7:0]}};
			end
			OP_LH, OP_LHU, OP_SH: begin
				misaligned = req_i.addr[0];
				sel = req_i.addr[1] ? 4'b1100 : 4'b0011;
				lane_data = {2{req_i.wdata[15:0]}};
			end
			default: begin
				misaligned = |req_i.addr[1:0];
				sel = 4'b1111;
			end
		endcase
	end

	// bring the addressed lanes down to bit 0, then extend.
	assign shifted = bus_rdata_i >> {req_i.addr[1:0], 3'b000};

	always_comb begin
		case (req_i.op)
			OP_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
			OP_LBU:  load_data = {24'h0, shifted[7:0]};
			OP_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
			OP_LHU:  load_data = {16'h0, shifted[15:0]};
			OP_LW:   load_data = shifted;
			default: load_data = '0; // stores return nothing.
		endcase
	end

	assign rsp_live.rdata = bus_err_i ? '0 : load_data;
	assign rsp_live.err = bus_err_i;

	assign bus_fin = (state_q == S_BUS) && bus_done_i;
	assign done_o = (state_q == S_DONE) || bus_fin;
	assign rsp_o = bus_fin ? rsp_live : rsp_q;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
			bus_en_o <= 1'b0;
			rsp_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (req_valid_i) begin
						if (misaligned) begin
							state_q <= S_DONE; // answered without a bus cycle.
							rsp_q <= '{rdata: '0, err: 1'b1};
						end else begin
							state_q <= S_BUS;
							bus_en_o <= 1'b1;
						end
					end
				end
				S_BUS: begin
					if (bus_done_i) begin
						state_q <= S_IDLE;
						bus_en_o <= 1'b0;
						rsp_q <= rsp_live;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (state_q == S_IDLE && req_valid_i) begin
			bus_req_o.we <= is_store;
			bus_req_o.sel <= sel;
			bus_req_o.adr <= (ADR_W-2)'(req_i.addr[ADDRESS_WIDTH-1:2]);
			bus_req_o.wdata <= lane_data;
		end
	end

	// the core keeps its request until done.
	a_req_held: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		(req_valid_i && !done_o) |=> (req_valid_i && $stable(req_i)));

endmodule

// File: verilog/dmem_pkg.sv
package dmem_pkg;

	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;
	localparam int ADR_W  = 32; // core byte address.

	// core side operation, loads first.
	typedef enum logic [2:0] {
		OP_LB  = 3'd0,
		OP_LBU = 3'd1,
		OP_LH  = 3'd2,
		OP_LHU = 3'd3,
		OP_LW  = 3'd4,
		OP_SB  = 3'd5,
		OP_SH  = 3'd6,
		OP_SW  = 3'd7
	} mem_op_e;

	typedef struct packed {
		mem_op_e             op;
		logic [ADR_W-1:0]    addr;
		logic [DATA_W-1:0]   wdata;
	} mem_req_t;

	typedef struct packed {
		logic [DATA_W-1:0]   rdata;
		logic                err; // valid with done.
	} mem_rsp_t;

	// word request towards the bus master.
	typedef struct packed {
		logic                we;
		logic [SEL_W-1:0]    sel;
		logic [ADR_W-3:0]    adr;
		logic [DATA_W-1:0]   wdata;
	} bus_req_t;

endpackage

// File: verilog/dmem_top.sv
module dmem_top #(
	parameter int ADDRESS_WIDTH = dmem_pkg::ADR_W,
	parameter int RAM_WORDS     = 256,
	parameter int ACK_LATENCY   = 2
) (
	input  logic                 wb_clk_i,
	input  logic                 rst_n_i,
	input  logic                 req_valid_i,
	input  dmem_pkg::mem_req_t   req_i,
	output logic                 done_o,
	output dmem_pkg::mem_rsp_t   rsp_o
);
	import dmem_pkg::*;

	logic                       bus_en;
	bus_req_t                   bus_req;
	logic                       bus_done;
	logic                       bus_err;
	logic [DATA_W-1:0]          bus_rdata;

	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	logic [SEL_W-1:0]           wb_sel;
	logic [ADDRESS_WIDTH-3:0]   wb_adr;
	logic [DATA_W-1:0]          wb_dat_m2s;
	logic [DATA_W-1:0]          wb_dat_s2m;
	logic                       wb_ack;
	logic                       wb_stall;
	logic                       wb_err;

	dmem_lsu #(
		.ADDRESS_WIDTH (ADDRESS_WIDTH)
	) u_lsu (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.done_o      (done_o),
		.rsp_o       (rsp_o),
		.bus_en_o    (bus_en),
		.bus_req_o   (bus_req),
		.bus_done_i  (bus_done),
		.bus_err_i   (bus_err),
		.bus_rdata_i (bus_rdata)
	);

	wb_master #(
		.ADDRESS_WIDTH (ADDRESS_WIDTH)
	) u_master (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.bus_en_i    (bus_en),
		.bus_req_i   (bus_req),
		.bus_done_o  (bus_done),
		.bus_err_o   (bus_err),
		.bus_rdata_o (bus_rdata),
		.wb_cyc_o    (wb_cyc),
		.wb_stb_o    (wb_stb),
		.wb_we_o     (wb_we),
		.wb_sel_o    (wb_sel),
		.wb_adr_o    (wb_adr),
		.wb_dat_o    (wb_dat_m2s),
		.wb_ack_i    (wb_ack),
		.wb_stall_i  (wb_stall),
		.wb_err_i    (wb_err),
		.wb_dat_i    (wb_dat_s2m)
	);

	wb_ram #(
		.ADDRESS_WIDTH (ADDRESS_WIDTH),
		.RAM_WORDS     (RAM_WORDS),
		.ACK_LATENCY   (ACK_LATENCY)
	) u_ram (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (wb_stb),
		.wb_we_i    (wb_we),
		.wb_sel_i   (wb_sel),
		.wb_adr_i   (wb_adr),
		.wb_dat_i   (wb_dat_m2s),
		.wb_ack_o   (wb_ack),
		.wb_stall_o (wb_stall),
		.wb_err_o   (wb_err),
		.wb_dat_o   (wb_dat_s2m)
	);

endmodule

// File: verilog/wb_master.sv
module wb_master #(
	parameter int ADDRESS_WIDTH = dmem_pkg::ADR_W
) (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic                          bus_en_i,
	input  dmem_pkg::bus_req_t            bus_req_i,
	output logic                          bus_done_o,
	output logic                          bus_err_o,
	output logic [dmem_pkg::DATA_W-1:0]   bus_rdata_o,
	output logic                          wb_cyc_o,
	output logic                          wb_stb_o,
	output logic                          wb_we_o,
	output logic [dmem_pkg::SEL_W-1:0]    wb_sel_o,
	output logic [ADDRESS_WIDTH-3:0]      wb_adr_o,
	output logic [dmem_pkg::DATA_W-1:0]   wb_dat_o,
	input  logic                          wb_ack_i,
	input  logic                          wb_stall_i,
	input  logic                          wb_err_i,
	input  logic [dmem_pkg::DATA_W-1:0]   wb_dat_i
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_WRITE_SINGLE,
		M_READ_SINGLE
	} state_e;

	state_e   state_q;
	logic     stb_q;
	logic     start;

	// bus_done_o blocks a restart while the unit still holds bus_en.
	assign start = (state_q == M_IDLE) && bus_en_i && !bus_done_o;

	assign wb_cyc_o = state_q != M_IDLE;
	assign wb_stb_o = stb_q;
	assign wb_we_o = state_q == M_WRITE_SINGLE;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= M_IDLE;
			stb_q <= 1'b0;
			bus_done_o <= 1'b0;
			bus_err_o <= 1'b0;
		end else begin
			bus_done_o <= 1'b0;
			case (state_q)
				M_IDLE: begin
					if (start) begin
						state_q <= bus_req_i.we ? M_WRITE_SINGLE : M_READ_SINGLE;
						stb_q <= 1'b1;
						bus_err_o <= 1'b0;
					end
				end
				M_WRITE_SINGLE, M_READ_SINGLE: begin
					if (!bus_en_i) begin
						state_q <= M_IDLE; // aborted by the unit.
						stb_q <= 1'b0;
					end else if (wb_ack_i || wb_err_i) begin
						state_q <= M_IDLE;
						stb_q <= 1'b0;
						bus_done_o <= 1'b1;
						bus_err_o <= wb_err_i;
					end else if (!wb_stall_i) begin
						stb_q <= 1'b0; // request taken.
					end
				end
				default: begin
					state_q <= M_IDLE;
					stb_q <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (start) begin
			wb_sel_o <= bus_req_i.sel;
			wb_adr_o <= bus_req_i.adr[ADDRESS_WIDTH-3:0];
			wb_dat_o <= bus_req_i.wdata;
		end
		if (state_q == M_READ_SINGLE && wb_ack_i) begin
			bus_rdata_o <= wb_dat_i;
		end
	end

	a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		wb_stb_o |-> wb_cyc_o);

	// the slave only answers a cycle that is open.
	a_no_idle_ack: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		(wb_ack_i || wb_err_i) |-> (state_q != M_IDLE));

endmodule

// File: verilog/wb_ram.sv
module wb_ram #(
	parameter int ADDRESS_WIDTH = dmem_pkg::ADR_W,
	parameter int RAM_WORDS     = 256,
	parameter int ACK_LATENCY   = 2
) (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	input  logic                          wb_we_i,
	input  logic [dmem_pkg::SEL_W-1:0]    wb_sel_i,
	input  logic [ADDRESS_WIDTH-3:0]      wb_adr_i,
	input  logic [dmem_pkg::DATA_W-1:0]   wb_dat_i,
	output logic                          wb_ack_o,
	output logic                          wb_stall_o,
	output logic                          wb_err_o,
	output logic [dmem_pkg::DATA_W-1:0]   wb_dat_o
);
	import dmem_pkg::*;

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
	localparam int CNT_W = $clog2(ACK_LATENCY + 1);

	logic [DATA_W-1:0]   mem [RAM_WORDS];
	logic [IDX_W-1:0]    idx;
	logic                in_range;
	logic                accept;
	logic                busy_q;
	logic                range_ok_q;
	logic [CNT_W-1:0]    cnt_q;
	logic                fin;

	assign idx = wb_adr_i[IDX_W-1:0];
	assign in_range = wb_adr_i < RAM_WORDS;
	assign accept = wb_cyc_i && wb_stb_i && !busy_q;

	assign fin = busy_q && (cnt_q == '0);
	assign wb_ack_o = fin && range_ok_q;
	assign wb_err_o = fin && !range_ok_q;
	assign wb_stall_o = busy_q; // one request at a time.

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			range_ok_q <= 1'b0;
			cnt_q <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			range_ok_q <= in_range;
			cnt_q <= CNT_W'(ACK_LATENCY - 1);
		end else if (fin) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// write happens at acceptance, per byte lane.
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int w = 0; w < RAM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else if (accept && wb_we_i && in_range) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (wb_sel_i[b]) begin
					mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			wb_dat_o <= (in_range && !wb_we_i) ? mem[idx] : '0;
		end
	end

	// every accepted request is answered after the set latency.
	a_latency: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		accept |-> ##ACK_LATENCY (wb_ack_o || wb_err_o));

endmodule
